// ==== hdl/accessDecode.sv ====
module accessDecode
	import bridgePkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      start,
	input  memReq_t   req,
	input  logic      accept,
	output accessOp_t op,
	output memReq_t   latchedReq,
	output accessOp_t latchedOp
);

	logic isUart;

	assign isUart = (req.addr == uartAddr);

	//////////////////////////////////////////////////////////////////////
	// Classification
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		op = opIdle;
		if (start) begin
			if (isUart) begin
				// No strobe at the UART address means nothing to do
				if (req.wr) begin
					op = opUartWrite;
				end else if (req.rd) begin
					op = opUartRead;
				end
			end else begin
				// Plain RAM access defaults to a read
				if (req.wr) begin
					op = opRamWrite;
				end else begin
					op = opRamRead;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Hold the accepted request for the whole access
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			latchedOp <= opIdle;
		end else if (accept) begin
			latchedOp <= op;
		end
	end

	// Address and write data
	always_ff @(posedge clk) begin
		if (accept) begin
			latchedReq <= req;
		end
	end

endmodule

// ==== hdl/bridgePkg.sv ====
package bridgePkg;

	//////////////////////////////////////////////////////////////////////
	// Widths with a meaning on the bus
	//////////////////////////////////////////////////////////////////////

	typedef logic [17:0] memAddr_t;
	typedef logic [15:0] memWord_t;
	typedef logic [7:0]  uartByte_t;
	typedef logic [1:0]  stepCount_t;

	// The single address decoded to the UART chip
	localparam memAddr_t uartAddr = 18'h0bf00;

	// Clocks spent in every sequencer state
	localparam int stepCycles = 4;
	localparam stepCount_t stepLast = stepCount_t'(stepCycles - 1);

	typedef enum logic [2:0] {
		opIdle,
		opRamRead,
		opRamWrite,
		opUartRead,
		opUartWrite
	} accessOp_t;

	typedef enum logic [3:0] {
		stIdle,
		stUartRead1,
		stUartRead2,
		stUartRead3,
		stUartWrite1,
		stUartWrite2,
		stUartWrite3,
		stUartWrite4,
		stUartWrite5,
		stRamRead1,
		stRamRead3,
		stRamWrite1,
		stRamWrite2,
		stRamWrite3
	} seqState_t;

	//////////////////////////////////////////////////////////////////////
	// Request and pin bundles
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic     rd;
		logic     wr;
		memAddr_t addr;
		memWord_t value;
	} memReq_t;

	// Strobes active low
	typedef struct packed {
		memAddr_t addr;
		memWord_t dataOut;
		logic     drive;
		logic     en;
		logic     oe;
		logic     we;
	} ramPins_t;

	typedef struct packed {
		uartByte_t dataOut;
		logic      drive;
		logic      rdn;
		logic      wrn;
	} uartPins_t;

endpackage

// ==== hdl/busSequencer.sv ====
module busSequencer
	import bridgePkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  accessOp_t op,
	input  memReq_t   latchedReq,
	input  logic      dataReady,
	input  logic      tbre,
	input  logic      tsre,
	output logic      accept,
	output logic      capture,
	output logic      finish,
	output ramPins_t  ram,
	output uartPins_t uart
);

	seqState_t  state;
	seqState_t  nextState;
	stepCount_t step;
	logic       stepWrap;

	logic ramEn;
	logic ramOe;
	logic ramWe;
	logic ramDrive;
	logic uartRdn;
	logic uartWrn;
	logic uartDrive;

	logic ramEnNext;
	logic ramOeNext;
	logic ramWeNext;
	logic ramDriveNext;
	logic uartRdnNext;
	logic uartWrnNext;
	logic uartDriveNext;

	//////////////////////////////////////////////////////////////////////
	// Step pacing
	//////////////////////////////////////////////////////////////////////

	assign stepWrap = (step == stepLast);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			step <= '0;
		end else if (stepWrap) begin
			step <= '0;
		end else begin
			step <= step + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// State machine
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		nextState = state;
		if (stepWrap) begin
			case (state)
				stIdle: begin
					case (op)
						opRamRead:   nextState = stRamRead1;
						opRamWrite:  nextState = stRamWrite1;
						opUartRead:  nextState = stUartRead1;
						opUartWrite: nextState = stUartWrite1;
						default:     nextState = stIdle;
					endcase
				end
				// Wait for a received byte
				stUartRead1: begin
					if (dataReady) begin
						nextState = stUartRead2;
					end
				end
				stUartRead2:  nextState = stUartRead3;
				stUartRead3:  nextState = stIdle;
				stUartWrite1: nextState = stUartWrite2;
				stUartWrite2: nextState = stUartWrite3;
				// Holding register empty, then shifter empty
				stUartWrite3: begin
					if (tbre) begin
						nextState = stUartWrite4;
					end
				end
				stUartWrite4: begin
					if (tsre) begin
						nextState = stUartWrite5;
					end
				end
				stUartWrite5: nextState = stIdle;
				stRamRead1:   nextState = stRamRead3;
				stRamRead3:   nextState = stIdle;
				stRamWrite1:  nextState = stRamWrite2;
				stRamWrite2:  nextState = stRamWrite3;
				stRamWrite3:  nextState = stIdle;
				default:      nextState = stIdle;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= stIdle;
		end else begin
			state <= nextState;
		end
	end

	assign accept  = stepWrap && (state == stIdle) && (op != opIdle);
	assign capture = stepWrap && (state inside {stRamRead3, stUartRead3});
	assign finish  = stepWrap &&
		(state inside {stRamRead3, stRamWrite3, stUartRead3, stUartWrite5});

	//////////////////////////////////////////////////////////////////////
	// Chip strobes, registered so they switch on state entry
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		ramEnNext     = 1'b1;
		ramOeNext     = 1'b1;
		ramWeNext     = 1'b1;
		ramDriveNext  = 1'b0;
		uartRdnNext   = 1'b1;
		uartWrnNext   = 1'b1;
		uartDriveNext = 1'b0;
		case (nextState)
			stRamRead1, stRamRead3: begin
				ramEnNext = 1'b0;
				ramOeNext = 1'b0;
			end
			stRamWrite1, stRamWrite3: begin
				ramEnNext    = 1'b0;
				ramDriveNext = 1'b1;
			end
			stRamWrite2: begin
				ramEnNext    = 1'b0;
				ramWeNext    = 1'b0;
				ramDriveNext = 1'b1;
			end
			stUartRead2: uartRdnNext = 1'b0;
			// Byte stays on the pins past the rising wrn edge
			stUartWrite1, stUartWrite3: uartDriveNext = 1'b1;
			stUartWrite2: begin
				uartDriveNext = 1'b1;
				uartWrnNext   = 1'b0;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ramEn     <= 1'b1;
			ramOe     <= 1'b1;
			ramWe     <= 1'b1;
			ramDrive  <= 1'b0;
			uartRdn   <= 1'b1;
			uartWrn   <= 1'b1;
			uartDrive <= 1'b0;
		end else begin
			ramEn     <= ramEnNext;
			ramOe     <= ramOeNext;
			ramWe     <= ramWeNext;
			ramDrive  <= ramDriveNext;
			uartRdn   <= uartRdnNext;
			uartWrn   <= uartWrnNext;
			uartDrive <= uartDriveNext;
		end
	end

	assign ram = '{
		addr:    latchedReq.addr,
		dataOut: latchedReq.value,
		drive:   ramDrive,
		en:      ramEn,
		oe:      ramOe,
		we:      ramWe
	};

	assign uart = '{
		dataOut: latchedReq.value[7:0],
		drive:   uartDrive,
		rdn:     uartRdn,
		wrn:     uartWrn
	};

endmodule

// ==== hdl/memUartBridge.sv ====
module memUartBridge
	import bridgePkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      start,
	input  memReq_t   req,
	input  memWord_t  ramDataIn,
	input  uartByte_t uartDataIn,
	input  logic      dataReady,
	input  logic      tbre,
	input  logic      tsre,
	output ramPins_t  ram,
	output uartPins_t uart,
	output memWord_t  result,
	output logic      done
);

	accessOp_t op;
	accessOp_t latchedOp;
	memReq_t   latchedReq;
	logic      accept;
	logic      capture;
	logic      finish;

	//////////////////////////////////////////////////////////////////////
	// Decode, execute, result
	//////////////////////////////////////////////////////////////////////

	accessDecode i_decode (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.req        (req),
		.accept     (accept),
		.op         (op),
		.latchedReq (latchedReq),
		.latchedOp  (latchedOp)
	);

	busSequencer i_sequencer (
		.clk        (clk),
		.rst        (rst),
		.op         (op),
		.latchedReq (latchedReq),
		.dataReady  (dataReady),
		.tbre       (tbre),
		.tsre       (tsre),
		.accept     (accept),
		.capture    (capture),
		.finish     (finish),
		.ram        (ram),
		.uart       (uart)
	);

	resultCapture i_result (
		.clk        (clk),
		.rst        (rst),
		.capture    (capture),
		.finish     (finish),
		.accept     (accept),
		.latchedOp  (latchedOp),
		.ramDataIn  (ramDataIn),
		.uartDataIn (uartDataIn),
		.result     (result),
		.done       (done)
	);

endmodule

// ==== hdl/resultCapture.sv ====
module resultCapture
	import bridgePkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      capture,
	input  logic      finish,
	input  logic      accept,
	input  accessOp_t latchedOp,
	input  memWord_t  ramDataIn,
	input  uartByte_t uartDataIn,
	output memWord_t  result,
	output logic      done
);

	localparam int padBits = $bits(memWord_t) - $bits(uartByte_t);

	memWord_t uartWide;
	memWord_t readWord;

	// UART byte lands in the low half
	assign uartWide = {{padBits{1'b0}}, uartDataIn};

	always_comb begin
		if (latchedOp == opUartRead) begin
			readWord = uartWide;
		end else begin
			readWord = ramDataIn;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Result register and done level
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			result <= '0;
		end else if (capture) begin
			result <= readWord;
		end
	end

	// Set when an access ends, cleared when the next one starts
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			done <= 1'b0;
		end else if (finish) begin
			done <= 1'b1;
		end else if (accept) begin
			done <= 1'b0;
		end
	end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module bridgeTb -f verilog.f

output=$(./obj_dir/VbridgeTb)
echo "$output"

if grep -qx "PASS: all tests" <<< "$output"; then
	exit 0
else
	exit 1
fi

// ==== test/bridgeChecker.sv ====
module bridgeChecker
	import bridgePkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        done,
	input  memWord_t    result,
	input  ramPins_t    ram,
	input  uartPins_t   uart,
	input  logic        tbre,
	input  logic        tsre,
	input  logic [79:0] testName,
	input  memWord_t    expResult,
	input  uartByte_t   expByte,
	input  logic        checkRead,
	input  logic        checkWrite,
	input  logic        quiet,
	input  logic        allDone,
	output int          errors
);

	timeunit 1ns;
	timeprecision 1ps;

	int         errorCount = 0;
	int         checks = 0;
	logic       rstSeen = 1'b0;
	logic       lastDone = 1'b0;
	logic       lastWrn = 1'b0;
	logic [7:0] pins;
	logic [7:0] lastPins = '0;
	logic [7:0] txBus;

	assign errors = errorCount;
	assign pins = {done, ram.drive, uart.drive, ram.en, ram.oe, ram.we, uart.rdn, uart.wrn};

	// Data lines float high when not driven
	assign txBus = uart.drive ? uart.dataOut : 8'hff;

	task automatic compareValue(input logic [79:0] name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errorCount++;
			$display("ERROR %0s: expected %h, got %h", name, expected, actual);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Sampled on the clock, DUT outputs are settled here
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		// Strobes high, drives and done low
		if (rst && !rstSeen) begin
			compareValue("resetState", 32'h0000_001f, {24'h0, pins});
			compareValue("resetValue", 32'h0000_0000, {16'h0, result});
		end
		if (done && !lastDone) begin
			if (checkRead) begin
				compareValue(testName, {16'h0, expResult}, {16'h0, result});
			end
			if (!(tbre && tsre)) begin
				errorCount++;
				$display("Done rose in %0s while the UART transmitter was still busy", testName);
			end
		end
		if (rst && uart.wrn && !lastWrn) begin
			if (checkWrite) begin
				compareValue(testName, {24'h0, expByte}, {24'h0, txBus});
			end else begin
				errorCount++;
				$display("Unexpected UART write strobe during %0s", testName);
			end
		end
		if (quiet && pins !== lastPins) begin
			errorCount++;
			$display("Done or a chip strobe moved during %0s", testName);
		end
		rstSeen  <= rst;
		lastDone <= done;
		lastWrn  <= uart.wrn;
		lastPins <= pins;
	end

	always @(posedge allDone) begin
		$display("Checks run: %0d, errors: %0d", checks, errorCount);
	end

endmodule

// ==== test/bridgeTb.sv ====
module bridgeTb
	import bridgePkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		logic [79:0] name;
		logic        rd;
		logic        wr;
		memAddr_t    addr;
		memWord_t    value;
		memWord_t    expected;
	} testEntry_t;

	localparam int numTests = 11;

	logic        clk = 1'b0;
	logic        rst;
	logic        start;
	memReq_t     req;
	memWord_t    ramDataIn;
	uartByte_t   uartDataIn;
	logic        dataReady;
	logic        tbre;
	logic        tsre;
	ramPins_t    ram;
	uartPins_t   uart;
	memWord_t    result;
	logic        done;

	testEntry_t  tests [numTests];
	logic [79:0] testName;
	memWord_t    expResult;
	uartByte_t   expByte;
	logic        checkRead;
	logic        checkWrite;
	logic        quiet;
	logic        allDone;
	int          errors;

	always #2 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Stimulus table
	//////////////////////////////////////////////////////////////////////

	task automatic loadTable();
		// Ignored request first, while done is still low
		tests[0]  = '{"uartIgnore", 1'b0, 1'b0, uartAddr,  16'h0000, 16'h0000};
		tests[1]  = '{"ramWr00012", 1'b0, 1'b1, 18'h00012, 16'hbeef, 16'h0000};
		tests[2]  = '{"ramWr000a5", 1'b0, 1'b1, 18'h000a5, 16'h1234, 16'h0000};
		tests[3]  = '{"ramWr3ff5a", 1'b0, 1'b1, 18'h3ff5a, 16'hc0de, 16'h0000};
		tests[4]  = '{"ramRd00012", 1'b1, 1'b0, 18'h00012, 16'h0000, 16'hbeef};
		tests[5]  = '{"ramRd3ff5a", 1'b1, 1'b0, 18'h3ff5a, 16'h0000, 16'hc0de};
		tests[6]  = '{"ramNone0a5", 1'b0, 1'b0, 18'h000a5, 16'h0000, 16'h1234};
		tests[7]  = '{"uartWrite1", 1'b0, 1'b1, uartAddr,  16'h7e41, 16'h0000};
		tests[8]  = '{"uartRead01", 1'b1, 1'b0, uartAddr,  16'h0000, 16'h005a};
		tests[9]  = '{"uartWrite2", 1'b0, 1'b1, uartAddr,  16'h12c3, 16'h0000};
		tests[10] = '{"uartRead02", 1'b1, 1'b0, uartAddr,  16'h0000, 16'h00a7};
	endtask

	task automatic runTest(input testEntry_t t);
		logic ignored;
		ignored = (t.addr == uartAddr) && !t.rd && !t.wr;
		@(posedge clk);
		#1;
		testName = t.name;
		expResult = t.expected;
		expByte = t.value[7:0];
		checkRead = !t.wr && !ignored;
		checkWrite = t.wr && (t.addr == uartAddr);
		req = '{rd: t.rd, wr: t.wr, addr: t.addr, value: t.value};
		start = 1'b1;
		if (ignored) begin
			quiet = 1'b1;
			repeat (20 * stepCycles) @(posedge clk);
			#1;
			quiet = 1'b0;
		end else begin
			// Done drops on accept and rises at the end
			wait (!done);
			wait (done);
			@(posedge clk);
			#1;
		end
		start = 1'b0;
		repeat (stepCycles) @(posedge clk);
	endtask

	initial begin
		void'($urandom(32'hebbb));
		rst = 1'b0;
		start = 1'b0;
		req = '0;
		testName = '0;
		expResult = '0;
		expByte = '0;
		checkRead = 1'b0;
		checkWrite = 1'b0;
		quiet = 1'b0;
		allDone = 1'b0;
		loadTable();
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b1;
		for (int i = 0; i < numTests; i++) begin
			runTest(tests[i]);
		end
		allDone = 1'b1;
		#1;
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (numTests * 200) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d clocks", numTests * 200);
		allDone = 1'b1;
		#1;
		$display("FAIL: see errors above");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// DUT, chip models and checker
	//////////////////////////////////////////////////////////////////////

	memUartBridge i_dut (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.req        (req),
		.ramDataIn  (ramDataIn),
		.uartDataIn (uartDataIn),
		.dataReady  (dataReady),
		.tbre       (tbre),
		.tsre       (tsre),
		.ram        (ram),
		.uart       (uart),
		.result     (result),
		.done       (done)
	);

	deviceModels i_models (
		.clk        (clk),
		.rst        (rst),
		.ram        (ram),
		.uart       (uart),
		.ramDataIn  (ramDataIn),
		.uartDataIn (uartDataIn),
		.dataReady  (dataReady),
		.tbre       (tbre),
		.tsre       (tsre)
	);

	bridgeChecker i_checker (
		.clk        (clk),
		.rst        (rst),
		.done       (done),
		.result     (result),
		.ram        (ram),
		.uart       (uart),
		.tbre       (tbre),
		.tsre       (tsre),
		.testName   (testName),
		.expResult  (expResult),
		.expByte    (expByte),
		.checkRead  (checkRead),
		.checkWrite (checkWrite),
		.quiet      (quiet),
		.allDone    (allDone),
		.errors     (errors)
	);

endmodule

// ==== test/deviceModels.sv ====
module deviceModels
	import bridgePkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  ramPins_t  ram,
	input  uartPins_t uart,
	output memWord_t  ramDataIn,
	output uartByte_t uartDataIn,
	output logic      dataReady,
	output logic      tbre,
	output logic      tsre
);

	timeunit 1ns;
	timeprecision 1ps;

	memWord_t  mem [256];
	uartByte_t rxQueue [$];
	uartByte_t rxHold;
	logic      weLine;
	logic      rdnLine;
	logic      wrnLine;

	assign weLine  = ram.we;
	assign rdnLine = uart.rdn;
	assign wrnLine = uart.wrn;

	//////////////////////////////////////////////////////////////////////
	// Asynchronous SRAM
	//////////////////////////////////////////////////////////////////////

	initial begin
		for (int i = 0; i < 256; i++) begin
			mem[i] = {~i[7:0], i[7:0]};
		end
		forever begin
			@(posedge weLine);
			if (rst && !ram.en) begin
				// Undriven data lines float high
				mem[ram.addr[7:0]] = ram.drive ? ram.dataOut : 16'hffff;
			end
		end
	end

	// Idle bus floats high
	assign ramDataIn = (!ram.en && !ram.oe) ? mem[ram.addr[7:0]] : 16'hffff;

	//////////////////////////////////////////////////////////////////////
	// UART chip
	//////////////////////////////////////////////////////////////////////

	// Receiver, one queued byte per read cycle
	initial begin
		dataReady = 1'b0;
		rxHold = '0;
		rxQueue.push_back(8'h5a);
		rxQueue.push_back(8'ha7);
		@(posedge rst);
		while (rxQueue.size() > 0) begin
			repeat ($urandom_range(20, 0)) @(posedge clk);
			#1;
			dataReady = 1'b1;
			@(negedge rdnLine);
			rxHold = rxQueue.pop_front();
			@(posedge rdnLine);
			#1;
			dataReady = 1'b0;
		end
	end

	// Last read byte stays on the lines
	assign uartDataIn = rxHold;

	// Transmitter, busy for a while after each write
	initial begin
		tbre = 1'b1;
		tsre = 1'b1;
		@(posedge rst);
		forever begin
			@(posedge wrnLine);
			tbre = 1'b0;
			tsre = 1'b0;
			repeat ($urandom_range(20, 1)) @(posedge clk);
			#1;
			tbre = 1'b1;
			repeat ($urandom_range(20, 1)) @(posedge clk);
			#1;
			tsre = 1'b1;
		end
	end

endmodule

// ==== verilog.f ====
hdl/bridgePkg.sv
hdl/accessDecode.sv
hdl/busSequencer.sv
hdl/resultCapture.sv
hdl/memUartBridge.sv
test/deviceModels.sv
test/bridgeChecker.sv
test/bridgeTb.sv
